// ==== source/logFormatPkg.sv ====
package logFormatPkg;

	localparam int expBits = 4;
	localparam int fracBits = 8;
	localparam int magBits = expBits + fracBits;
	// zero flag and sign on top of the magnitude
	localparam int logBits = magBits + 2;

	// exponent and fraction as the converter builds them
	typedef struct packed {
		logic zero;
		logic sign;
		logic [expBits-1:0] exponent;
		logic [fracBits-1:0] fraction;
	} logFields_t;

	// exponent.fraction read as one fixed-point log2
	typedef struct packed {
		logic zero;
		logic sign;
		logic [magBits-1:0] magnitude;
	} logMag_t;

	typedef union packed {
		logFields_t fields;
		logMag_t mag;
	} logWord_u;

	// the value zero, used as the reset word
	localparam logWord_u logZero = logWord_u'({1'b1, {(logBits-1){1'b0}}});

endpackage

// ==== source/correlatorPkg.sv ====
package correlatorPkg;

	localparam int pixelBits = 8;

	typedef logic signed [pixelBits-1:0] pixel_t;

	// products peak near 2**14, so a row of eight still fits
	localparam int accBits = 20;

	typedef logic signed [accBits-1:0] acc_t;

endpackage

// ==== source/logConverter.sv ====
`timescale 1ns/1ps

module logConverter import logFormatPkg::*, correlatorPkg::*; (
	input pixel_t pixel,
	output logWord_u logWord
);

	logic [pixelBits-1:0] absPixel;
	logic [3:0] searchHigh;
	logic [1:0] searchLow;
	logic [2:0] oneIndex;
	logic [pixelBits+fracBits-1:0] aligned;

	// -128 comes out as unsigned 128
	assign absPixel = pixel[pixelBits-1] ? -pixel : pixel;

	// leading one, halving the field each step
	always_comb begin
		oneIndex[2] = |absPixel[7:4];
		searchHigh = oneIndex[2] ? absPixel[7:4] : absPixel[3:0];
		oneIndex[1] = |searchHigh[3:2];
		searchLow = oneIndex[1] ? searchHigh[3:2] : searchHigh[1:0];
		oneIndex[0] = searchLow[1];
	end

	// bits under the leading one slide up into the fraction
	assign aligned = {absPixel, {fracBits{1'b0}}} >> oneIndex;

	always_comb begin
		logWord.fields.zero = (pixel == '0);
		logWord.fields.sign = pixel[pixelBits-1];
		logWord.fields.exponent = expBits'(oneIndex);
		logWord.fields.fraction = aligned[fracBits-1:0];
	end

endmodule

// ==== source/logProductElement.sv ====
`timescale 1ns/1ps

module logProductElement import logFormatPkg::*, correlatorPkg::*; (
	input logWord_u descWord,
	input logWord_u winWord,
	output acc_t product
);

	localparam int linBits = 2**expBits + fracBits;

	logic [magBits-1:0] logSum;
	logic [linBits-1:0] linear;
	logic [linBits-fracBits-1:0] magnitude;

	// multiply in the log domain
	assign logSum = descWord.mag.magnitude + winWord.mag.magnitude;

	// piecewise-linear antilog: 1.frac shifted by the integer part
	assign linear = linBits'({1'b1, logSum[fracBits-1:0]}) << logSum[magBits-1:fracBits];
	assign magnitude = linear[linBits-1:fracBits];

	always_comb begin
		if (descWord.mag.zero || winWord.mag.zero) begin
			product = '0;
		end else if (descWord.mag.sign ^ winWord.mag.sign) begin
			product = -acc_t'(magnitude);
		end else begin
			product = acc_t'(magnitude);
		end
	end

	// pixel exponents top out at 7, so the sum never reaches past 2**15
	always_comb begin
		productBound: assert final (magnitude <= 16'h8000)
			else $error("log product magnitude %0d above 2**15", magnitude);
	end

endmodule

// ==== source/correlationArray.sv ====
`timescale 1ns/1ps

module correlationArray import logFormatPkg::*, correlatorPkg::*; #(
	parameter int numRows = 4,
	parameter int numCols = 4
) (
	input logic clk,
	input logic rst,
	input logic writeDesc,
	input logic [$clog2(numRows*numCols)-1:0] descIndex,
	input logWord_u descWord,
	input logic shiftWin,
	input logWord_u winWord,
	input logic captureScores,
	input logic [$clog2(numRows)-1:0] resultRow,
	output acc_t resultValue
);

	localparam int numCells = numRows * numCols;

	logWord_u descRegs [numCells];
	logWord_u winRegs [numCols];
	acc_t products [numRows][numCols];
	acc_t rowSums [numRows];
	acc_t scores [numRows];

	// row-major, index = row * numCols + col
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < numCells; i++) begin
				descRegs[i] <= logZero;
			end
		end else if (writeDesc) begin
			descRegs[descIndex] <= descWord;
		end
	end

	// newest pixel enters at tap 0
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int c = 0; c < numCols; c++) begin
				winRegs[c] <= logZero;
			end
		end else if (shiftWin) begin
			winRegs[0] <= winWord;
			for (int c = 1; c < numCols; c++) begin
				winRegs[c] <= winRegs[c-1];
			end
		end
	end

	for (genvar r = 0; r < numRows; r++) begin : gRow
		for (genvar c = 0; c < numCols; c++) begin : gCol
			logProductElement element (
				.descWord(descRegs[r*numCols + c]),
				.winWord(winRegs[c]),
				.product(products[r][c])
			);
		end
	end

	always_comb begin
		for (int r = 0; r < numRows; r++) begin
			rowSums[r] = '0;
			for (int c = 0; c < numCols; c++) begin
				rowSums[r] = rowSums[r] + products[r][c];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (captureScores) begin
			scores <= rowSums;
		end
	end

	assign resultValue = scores[resultRow];

endmodule

// ==== source/correlatorControl.sv ====
`timescale 1ns/1ps

module correlatorControl #(
	parameter int numRows = 4,
	parameter int numCols = 4
) (
	input logic clk,
	input logic rst,
	input logic descReq,
	output logic descAck,
	input logic winReq,
	output logic winAck,
	output logic resultReq,
	input logic resultAck,
	output logic writeDesc,
	output logic [$clog2(numRows*numCols)-1:0] descIndex,
	output logic shiftWin,
	output logic captureScores,
	output logic [$clog2(numRows)-1:0] resultRow
);

	localparam int numCells = numRows * numCols;
	localparam int indexBits = $clog2(numCells);
	localparam int rowBits = $clog2(numRows);
	localparam int fillBits = $clog2(numCols + 1);

	typedef enum logic [2:0] {
		sIdle,
		sDescWrite,
		sDescAck,
		sWinShift,
		sCapture,
		sResultReq,
		sResultRelease,
		sWinAck
	} state_t;

	state_t state, nextState;
	logic [fillBits-1:0] fillCount;
	logic windowFull;
	logic lastRow;

	assign windowFull = (fillCount == fillBits'(numCols));
	assign lastRow = (resultRow == rowBits'(numRows - 1));

	always_comb begin
		nextState = state;
		case (state)
			// descriptor wins a tie
			sIdle: begin
				if (descReq) begin
					nextState = sDescWrite;
				end else if (winReq) begin
					nextState = sWinShift;
				end
			end
			sDescWrite: nextState = sDescAck;
			sDescAck: begin
				if (!descReq) begin
					nextState = sIdle;
				end
			end
			sWinShift: nextState = sCapture;
			// no results until the window is filled
			sCapture: nextState = windowFull ? sResultReq : sWinAck;
			sResultReq: begin
				if (resultAck) begin
					nextState = sResultRelease;
				end
			end
			sResultRelease: begin
				if (!resultAck) begin
					nextState = lastRow ? sWinAck : sResultReq;
				end
			end
			sWinAck: begin
				if (!winReq) begin
					nextState = sIdle;
				end
			end
			default: nextState = sIdle;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= sIdle;
			descIndex <= '0;
			fillCount <= '0;
			resultRow <= '0;
		end else begin
			state <= nextState;
			if (writeDesc) begin
				descIndex <= (descIndex == indexBits'(numCells - 1)) ? '0 : descIndex + 1'b1;
			end
			if (shiftWin && !windowFull) begin
				fillCount <= fillCount + 1'b1;
			end
			if (state == sResultRelease && !resultAck) begin
				resultRow <= lastRow ? '0 : resultRow + 1'b1;
			end
		end
	end

	assign writeDesc = (state == sDescWrite);
	assign descAck = (state == sDescAck);
	assign shiftWin = (state == sWinShift);
	assign captureScores = (state == sCapture);
	assign resultReq = (state == sResultReq);
	assign winAck = (state == sWinAck);

	// sink must have taken the result before it is withdrawn
	reqHeldUntilAck: assert property (@(posedge clk) disable iff (rst)
		$fell(resultReq) |-> $past(resultAck));

	ackExclusive: assert property (@(posedge clk) disable iff (rst)
		!(descAck && winAck));

	strobeExclusive: assert property (@(posedge clk) disable iff (rst)
		!(writeDesc && shiftWin));

endmodule

// ==== source/logCorrelator.sv ====
`timescale 1ns/1ps

module logCorrelator import logFormatPkg::*, correlatorPkg::*; #(
	parameter int numRows = 4,
	parameter int numCols = 4
) (
	input logic clk,
	input logic rst,
	input logic descReq,
	input pixel_t descData,
	output logic descAck,
	input logic winReq,
	input pixel_t winData,
	output logic winAck,
	output logic resultReq,
	input logic resultAck,
	output logic [$clog2(numRows)-1:0] resultRow,
	output acc_t resultValue
);

	localparam int indexBits = $clog2(numRows * numCols);

	logic writeDesc;
	logic shiftWin;
	logic captureScores;
	logic [indexBits-1:0] descIndex;
	logWord_u descWord;
	logWord_u winWord;

	correlatorControl #(
		.numRows(numRows),
		.numCols(numCols)
	) control (
		.clk(clk),
		.rst(rst),
		.descReq(descReq),
		.descAck(descAck),
		.winReq(winReq),
		.winAck(winAck),
		.resultReq(resultReq),
		.resultAck(resultAck),
		.writeDesc(writeDesc),
		.descIndex(descIndex),
		.shiftWin(shiftWin),
		.captureScores(captureScores),
		.resultRow(resultRow)
	);

	logConverter descConverter (
		.pixel(descData),
		.logWord(descWord)
	);

	logConverter winConverter (
		.pixel(winData),
		.logWord(winWord)
	);

	correlationArray #(
		.numRows(numRows),
		.numCols(numCols)
	) array (
		.clk(clk),
		.rst(rst),
		.writeDesc(writeDesc),
		.descIndex(descIndex),
		.descWord(descWord),
		.shiftWin(shiftWin),
		.winWord(winWord),
		.captureScores(captureScores),
		.resultRow(resultRow),
		.resultValue(resultValue)
	);

endmodule

// ==== tests/correlatorModel.svh ====
// 32-bit Galois LFSR, one step per bit taken
logic [31:0] lfsrState = 32'h2783;

function automatic logic [31:0] lfsrStep(input logic [31:0] state);
	return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
endfunction

function automatic int randomBits(input int count);
	int value;
	value = 0;
	for (int i = 0; i < count; i++) begin
		lfsrState = lfsrStep(lfsrState);
		value = (value << 1) | int'(lfsrState[0]);
	end
	return value;
endfunction

// exponent * 256 + fraction for a nonzero magnitude up to 128
function automatic int logMagnitude(input int absVal);
	int exponent;
	exponent = 0;
	for (int b = 0; b < 8; b++) begin
		if (absVal >= (1 << b)) begin
			exponent = b;
		end
	end
	return exponent * 256 + (((absVal << 8) >> exponent) & 255);
endfunction

function automatic int mitchellProduct(input int a, input int b);
	int logSum;
	int magnitude;
	if (a == 0 || b == 0) begin
		return 0;
	end
	logSum = logMagnitude(a < 0 ? -a : a) + logMagnitude(b < 0 ? -b : b);
	// antilog, truncated to an integer
	magnitude = ((256 + logSum % 256) << (logSum / 256)) >> 8;
	return ((a < 0) != (b < 0)) ? -magnitude : magnitude;
endfunction

function automatic int rowScore(input int row, input descArray_t descVals,
		input winArray_t winVals, input bit exact);
	int sum;
	sum = 0;
	for (int c = 0; c < numCols; c++) begin
		if (exact) begin
			sum += descVals[row * numCols + c] * winVals[c];
		end else begin
			sum += mitchellProduct(descVals[row * numCols + c], winVals[c]);
		end
	end
	return sum;
endfunction

// ==== tests/logCorrelatorTb.sv ====
`timescale 1ns/1ps

module logCorrelatorTb import correlatorPkg::*; ();

	localparam int numRows = 4;
	localparam int numCols = 4;
	localparam int numCells = numRows * numCols;
	localparam int rowBits = $clog2(numRows);
	localparam int timeoutCycles = 200;

	typedef int descArray_t [numCells];
	typedef int winArray_t [numCols];

	`include "correlatorModel.svh"

	logic clk;
	logic rst;
	logic descReq;
	pixel_t descData;
	logic descAck;
	logic winReq;
	pixel_t winData;
	logic winAck;
	logic resultReq;
	logic resultAck;
	logic [rowBits-1:0] resultRow;
	acc_t resultValue;

	descArray_t descModel;
	winArray_t winModel;
	int filled;
	int loadIndex;
	bit exactMode;
	int expRows[$];
	int expValues[$];
	int valueErrors;
	int protocolErrors;
	int timeoutErrors;
	event timeoutSeen;

	logCorrelator #(
		.numRows(numRows),
		.numCols(numCols)
	) dut (
		.clk(clk),
		.rst(rst),
		.descReq(descReq),
		.descData(descData),
		.descAck(descAck),
		.winReq(winReq),
		.winData(winData),
		.winAck(winAck),
		.resultReq(resultReq),
		.resultAck(resultAck),
		.resultRow(resultRow),
		.resultValue(resultValue)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic finishRun();
		$display("errors: %0d value, %0d protocol, %0d timeout",
			valueErrors, protocolErrors, timeoutErrors);
		if (valueErrors + protocolErrors + timeoutErrors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic reportTimeout(input string what);
		timeoutErrors++;
		$display("timeout: %s", what);
		->timeoutSeen;
	endtask

	// zero and -128 show up more often than a flat draw would give
	function automatic int randomPixel();
		int pick;
		pick = randomBits(3);
		if (pick == 0) begin
			return 0;
		end else if (pick == 1) begin
			return -128;
		end
		return randomBits(8) - 128;
	endfunction

	function automatic int powerOfTwo(input int i);
		int magnitude;
		magnitude = 1 << (i % 8);
		if (magnitude == 128) begin
			return -128;
		end
		return (i % 3 == 1) ? -magnitude : magnitude;
	endfunction

	task automatic loadDesc(input int value);
		int cycles;
		descModel[loadIndex] = value;
		loadIndex = (loadIndex + 1) % numCells;
		descData = pixel_t'(value);
		descReq = 1'b1;
		cycles = 0;
		while (!descAck && cycles < timeoutCycles) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!descAck) begin
			reportTimeout("descAck never rose");
		end
		descReq = 1'b0;
		cycles = 0;
		while (descAck && cycles < timeoutCycles) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (descAck) begin
			reportTimeout("descAck never fell");
		end
	endtask

	task automatic sendWin(input int value);
		int cycles;
		for (int c = numCols - 1; c > 0; c--) begin
			winModel[c] = winModel[c-1];
		end
		winModel[0] = value;
		if (filled < numCols) begin
			filled++;
		end
		if (filled == numCols) begin
			for (int r = 0; r < numRows; r++) begin
				expRows.push_back(r);
				expValues.push_back(rowScore(r, descModel, winModel, exactMode));
			end
		end
		winData = pixel_t'(value);
		winReq = 1'b1;
		cycles = 0;
		while (!winAck && cycles < timeoutCycles) begin
			@(posedge clk);
			#1;
			cycles++;
			ackAfterResults: assert (!(winAck && expRows.size() != 0)) else begin
				protocolErrors++;
				$display("winAck rose with %0d results still pending", expRows.size());
			end
		end
		if (!winAck) begin
			reportTimeout("winAck never rose");
		end
		winReq = 1'b0;
		cycles = 0;
		while (winAck && cycles < timeoutCycles) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (winAck) begin
			reportTimeout("winAck never fell");
		end
	endtask

	initial begin : timeoutWatch
		@(timeoutSeen);
		finishRun();
	end

	// result sink with a random hold before each ack
	initial begin : resultChecker
		int hold;
		int cycles;
		resultAck = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (resultReq && !resultAck) begin
				resultExpected: assert (expRows.size() != 0) else begin
					protocolErrors++;
					$display("result request arrived when no result was expected");
				end
				if (expRows.size() != 0) begin
					rowCheck: assert (resultRow === rowBits'(expRows[0])) else begin
						valueErrors++;
						$display("error resultRow: got %h expected %h", resultRow, expRows[0]);
					end
					valueCheck: assert (resultValue === acc_t'(expValues[0])) else begin
						valueErrors++;
						$display("error resultValue row %h: got %h expected %h",
							resultRow, resultValue, acc_t'(expValues[0]));
					end
				end
				hold = randomBits(3);
				repeat (hold) begin
					@(posedge clk);
					#1;
				end
				resultAck = 1'b1;
				cycles = 0;
				while (resultReq && cycles < timeoutCycles) begin
					@(posedge clk);
					#1;
					cycles++;
				end
				if (resultReq) begin
					reportTimeout("resultReq never fell");
				end
				resultAck = 1'b0;
				if (expRows.size() != 0) begin
					void'(expRows.pop_front());
					void'(expValues.pop_front());
				end
			end
		end
	end

	initial begin : stimulus
		rst = 1'b1;
		descReq = 1'b0;
		descData = '0;
		winReq = 1'b0;
		winData = '0;
		exactMode = 1'b0;
		filled = 0;
		loadIndex = 0;
		for (int i = 0; i < numCells; i++) begin
			descModel[i] = 0;
		end
		for (int c = 0; c < numCols; c++) begin
			winModel[c] = 0;
		end
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		// empty descriptor, so the first full window scores zero
		for (int i = 0; i < numCols; i++) begin
			sendWin(randomPixel());
		end
		exactMode = 1'b1;
		for (int i = 0; i < numCells; i++) begin
			loadDesc(powerOfTwo(i));
		end
		for (int i = 0; i < 2 * numCols; i++) begin
			sendWin(powerOfTwo(i * 3 + 1));
		end
		exactMode = 1'b0;
		for (int i = 0; i < numCells; i++) begin
			loadDesc(randomPixel());
		end
		for (int i = 0; i < 40; i++) begin
			sendWin(randomPixel());
		end
		// reload mid-stream, window stays as it is
		for (int i = 0; i < numCells; i++) begin
			loadDesc(randomPixel());
		end
		for (int i = 0; i < 12; i++) begin
			sendWin(randomPixel());
		end
		allDelivered: assert (expRows.size() == 0) else begin
			protocolErrors++;
			$display("%0d expected results were never delivered", expRows.size());
		end
		finishRun();
	end

endmodule

// ==== verilog.f ====
+incdir+tests
source/logFormatPkg.sv
source/correlatorPkg.sv
source/logConverter.sv
source/logProductElement.sv
source/correlationArray.sv
source/correlatorControl.sv
source/logCorrelator.sv
tests/logCorrelatorTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= logCorrelatorTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_TEXT ?= Simulation failed
VFLAGS ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

SHELL := /bin/bash

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
